/* rtl/pkt_q_pkg.sv */
package pkt_q_pkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------
    localparam int NUM_BUFS      = 16;
    localparam int BUF_WORDS     = 4;
    localparam int MIN_PKT_WORDS = 2;
    localparam int MAX_PKT_WORDS = 16;
    localparam int DATA_WORDS    = NUM_BUFS * BUF_WORDS;

    localparam int PTR_WID      = $clog2(NUM_BUFS);
    localparam int OFS_WID      = $clog2(BUF_WORDS);
    localparam int ADDR_WID     = PTR_WID + OFS_WID;
    localparam int LEN_WID      = $clog2(MAX_PKT_WORDS + 1);
    localparam int DROP_CNT_WID = 16;

    // ----------------------------------------
    // Types
    // ----------------------------------------
    typedef logic [31:0]         data_t;
    typedef logic [PTR_WID-1:0]  buf_ptr_t;
    // Buffer number in the upper bits, word offset below
    typedef logic [ADDR_WID-1:0] word_addr_t;
    typedef logic [LEN_WID-1:0]  pkt_len_t;
    typedef logic [7:0]          meta_t;

    typedef struct packed {
        data_t data;
        logic  sop;
        logic  eop;
        logic  err;    // Only looked at together with eop
    } pkt_word_t;

    typedef struct packed {
        buf_ptr_t head;
        pkt_len_t len;
        meta_t    meta;
        logic     drop;    // Chain is released, not sent
    } pkt_desc_t;

endpackage : pkt_q_pkg

/* rtl/buf_ram.sv */
`timescale 1ns/100ps

module buf_ram #(
    parameter type DATA_T = logic,
    parameter int  DEPTH  = 16
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  DATA_T                    wr_data,
    input  logic                     rd_en,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output DATA_T                    rd_data
);

    DATA_T mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data holds until the next read strobe
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule : buf_ram

/* rtl/buf_alloc.sv */
`timescale 1ns/100ps

module buf_alloc
    import pkt_q_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     take,
    input  logic     recycle,
    input  buf_ptr_t recycle_ptr,
    output buf_ptr_t free_ptr,
    output logic     free_avail,
    output logic     init_done
);

    buf_ptr_t         store [NUM_BUFS];
    buf_ptr_t         rd_idx;
    buf_ptr_t         wr_idx;
    buf_ptr_t         init_cnt;
    logic [PTR_WID:0] count;
    logic             put;
    buf_ptr_t         put_ptr;

    // Fill and return share the write side of the store
    assign put     = init_done ? recycle : 1'b1;
    assign put_ptr = init_done ? recycle_ptr : init_cnt;

    assign free_ptr   = store[rd_idx];
    assign free_avail = init_done && (count != '0);

    always_ff @(posedge clk) begin
        if (put) begin
            store[wr_idx] <= put_ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_idx    <= '0;
            wr_idx    <= '0;
            init_cnt  <= '0;
            count     <= '0;
            init_done <= 1'b0;
        end else begin
            // One buffer number per cycle until the pool is full
            if (!init_done) begin
                init_cnt <= init_cnt + 1'b1;
                if (init_cnt == buf_ptr_t'(NUM_BUFS - 1)) begin
                    init_done <= 1'b1;
                end
            end
            if (put) begin
                wr_idx <= wr_idx + 1'b1;
            end
            if (take) begin
                rd_idx <= rd_idx + 1'b1;
            end
            // Take and return together leave the count as it is
            count <= count + {{PTR_WID{1'b0}}, put} - {{PTR_WID{1'b0}}, take};
        end
    end

endmodule : buf_alloc

/* rtl/desc_fifo.sv */
`timescale 1ns/100ps

module desc_fifo
    import pkt_q_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      push,
    input  pkt_desc_t push_desc,
    input  logic      pop,
    output pkt_desc_t head_desc,
    output logic      not_empty
);

    pkt_desc_t        q [NUM_BUFS];
    buf_ptr_t         wr_idx;
    buf_ptr_t         rd_idx;
    logic [PTR_WID:0] count;

    // Show-ahead head
    assign head_desc = q[rd_idx];
    assign not_empty = (count != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            q[wr_idx] <= push_desc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_idx <= '0;
            rd_idx <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_idx <= wr_idx + 1'b1;
            end
            if (pop) begin
                rd_idx <= rd_idx + 1'b1;
            end
            // At least one buffer per descriptor, so never more than NUM_BUFS entries
            count <= count + {{PTR_WID{1'b0}}, push} - {{PTR_WID{1'b0}}, pop};
        end
    end

endmodule : desc_fifo

/* rtl/pkt_scatter.sv */
`timescale 1ns/100ps

module pkt_scatter
    import pkt_q_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  pkt_word_t               in_word,
    input  meta_t                   in_meta,
    input  buf_ptr_t                free_ptr,
    input  logic                    free_avail,
    output logic                    take,
    output logic                    data_wr_en,
    output word_addr_t              data_wr_addr,
    output data_t                   data_wr_data,
    output logic                    link_wr_en,
    output buf_ptr_t                link_wr_addr,
    output buf_ptr_t                link_wr_data,
    output logic                    push,
    output pkt_desc_t               push_desc,
    output logic [DROP_CNT_WID-1:0] drop_cnt
);

    // Packet context
    logic     active;
    logic     held;
    logic     discard;
    pkt_len_t len;
    buf_ptr_t head;
    buf_ptr_t cur_buf;
    meta_t    meta;

    // Per-word decisions
    logic     start;
    logic     accept;
    logic     wanted;
    logic     room;
    logic     need_buf;
    logic     overlong;
    logic     no_buf;
    logic     keep_word;
    logic     held_next;
    logic     discard_next;
    logic     drop_now;
    pkt_len_t wr_len;
    pkt_len_t len_next;
    buf_ptr_t head_next;
    meta_t    meta_next;

    // ----------------------------------------
    // Word classification
    // ----------------------------------------
    always_comb begin
        // Start words while busy are treated as continuation
        start  = in_valid && !active && in_word.sop;
        accept = start || (in_valid && active);
        wr_len = start ? '0 : len;
        wanted = start || (accept && !discard);
        room   = (wr_len < pkt_len_t'(MAX_PKT_WORDS));

        // New buffer on every boundary
        need_buf  = wanted && room && (wr_len[OFS_WID-1:0] == '0);
        take      = need_buf && free_avail;
        overlong  = wanted && !room;
        no_buf    = need_buf && !free_avail;
        keep_word = wanted && room && !no_buf;

        len_next     = wr_len + pkt_len_t'(keep_word);
        head_next    = start ? free_ptr : head;
        meta_next    = start ? in_meta : meta;
        held_next    = start ? take : held;
        discard_next = (!start && discard) || overlong || no_buf;
        drop_now     = discard_next || in_word.err ||
                       (len_next < pkt_len_t'(MIN_PKT_WORDS));
    end

    // ----------------------------------------
    // Control
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            active     <= 1'b0;
            held       <= 1'b0;
            discard    <= 1'b0;
            len        <= '0;
            data_wr_en <= 1'b0;
            link_wr_en <= 1'b0;
            push       <= 1'b0;
            drop_cnt   <= '0;
        end else begin
            data_wr_en <= keep_word;
            // Chain link only when a packet moves to its next buffer
            link_wr_en <= take && !start;
            push       <= accept && in_word.eop && held_next;
            if (accept) begin
                active  <= !in_word.eop;
                held    <= held_next;
                discard <= discard_next;
                len     <= len_next;
                if (in_word.eop && drop_now) begin
                    drop_cnt <= drop_cnt + 1'b1;
                end
            end
        end
    end

    // ----------------------------------------
    // Payload
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (take) begin
            cur_buf <= free_ptr;
        end
        if (accept) begin
            head <= head_next;
            meta <= meta_next;
        end
        data_wr_addr <= {take ? free_ptr : cur_buf, wr_len[OFS_WID-1:0]};
        data_wr_data <= in_word.data;
        link_wr_addr <= cur_buf;
        link_wr_data <= free_ptr;
        push_desc    <= '{head: head_next, len: len_next, meta: meta_next, drop: drop_now};
    end

endmodule : pkt_scatter

/* rtl/pkt_gather.sv */
`timescale 1ns/100ps

module pkt_gather
    import pkt_q_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       drain_en,
    input  pkt_desc_t  head_desc,
    input  logic       not_empty,
    input  data_t      data_rd_data,
    input  buf_ptr_t   link_rd_data,
    output logic       pop,
    output logic       data_rd_en,
    output word_addr_t data_rd_addr,
    output logic       link_rd_en,
    output buf_ptr_t   link_rd_addr,
    output logic       recycle,
    output buf_ptr_t   recycle_ptr,
    output logic       out_valid,
    output pkt_word_t  out_word,
    output meta_t      out_meta
);

    logic               busy;
    logic               drop;
    pkt_len_t           cnt;
    pkt_len_t           len;
    buf_ptr_t           cur_buf;
    meta_t              meta;
    logic [OFS_WID-1:0] ofs;
    logic               step;
    logic               last;
    logic               buf_end;
    logic               sop_q;
    logic               eop_q;

    // ----------------------------------------
    // Chain walk
    // ----------------------------------------
    assign pop     = !busy && not_empty && drain_en;
    assign step    = busy && drain_en;
    assign ofs     = cnt[OFS_WID-1:0];
    assign last    = (pkt_len_t'(cnt + 1'b1) == len);
    assign buf_end = last || (ofs == OFS_WID'(BUF_WORDS - 1));

    // Dropped chains are walked at the same pace without data reads
    assign data_rd_en   = step && !drop;
    assign data_rd_addr = {cur_buf, ofs};

    // Link fetched on the first word, used at the last word of the buffer
    assign link_rd_en   = step && (ofs == '0);
    assign link_rd_addr = cur_buf;

    assign recycle     = step && buf_end;
    assign recycle_ptr = cur_buf;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            drop <= 1'b0;
            cnt  <= '0;
        end else if (pop) begin
            busy <= 1'b1;
            drop <= head_desc.drop;
            cnt  <= '0;
        end else if (step) begin
            cnt <= cnt + 1'b1;
            if (last) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            cur_buf <= head_desc.head;
            len     <= head_desc.len;
            meta    <= head_desc.meta;
        end else if (step && buf_end) begin
            cur_buf <= link_rd_data;
        end
    end

    // ----------------------------------------
    // Output aligned with the read data
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= data_rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (data_rd_en) begin
            sop_q    <= (cnt == '0);
            eop_q    <= last;
            out_meta <= meta;
        end
    end

    assign out_word = '{data: data_rd_data, sop: sop_q, eop: eop_q, err: 1'b0};

endmodule : pkt_gather

/* rtl/pkt_q_core.sv */
`timescale 1ns/100ps

module pkt_q_core
    import pkt_q_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    in_valid,
    input  pkt_word_t               in_word,
    input  meta_t                   in_meta,

    input  logic                    drain_en,
    output logic                    out_valid,
    output pkt_word_t               out_word,
    output meta_t                   out_meta,

    output logic                    init_done,
    output logic [DROP_CNT_WID-1:0] drop_cnt
);

    // ----------------------------------------
    // Signals
    // ----------------------------------------
    // Buffer pool
    logic       take;
    logic       free_avail;
    buf_ptr_t   free_ptr;
    logic       recycle;
    buf_ptr_t   recycle_ptr;

    // Descriptor queue
    logic       push;
    pkt_desc_t  push_desc;
    logic       pop;
    logic       not_empty;
    pkt_desc_t  head_desc;

    // Memory ports
    logic       data_wr_en;
    word_addr_t data_wr_addr;
    data_t      data_wr_data;
    logic       data_rd_en;
    word_addr_t data_rd_addr;
    data_t      data_rd_data;
    logic       link_wr_en;
    buf_ptr_t   link_wr_addr;
    buf_ptr_t   link_wr_data;
    logic       link_rd_en;
    buf_ptr_t   link_rd_addr;
    buf_ptr_t   link_rd_data;

    // ----------------------------------------
    // Memories
    // ----------------------------------------
    buf_ram #(
        .DATA_T ( data_t ),
        .DEPTH  ( DATA_WORDS )
    ) i_data_ram (
        .clk,
        .wr_en   ( data_wr_en ),
        .wr_addr ( data_wr_addr ),
        .wr_data ( data_wr_data ),
        .rd_en   ( data_rd_en ),
        .rd_addr ( data_rd_addr ),
        .rd_data ( data_rd_data )
    );

    // One next-buffer pointer per buffer
    buf_ram #(
        .DATA_T ( buf_ptr_t ),
        .DEPTH  ( NUM_BUFS )
    ) i_link_ram (
        .clk,
        .wr_en   ( link_wr_en ),
        .wr_addr ( link_wr_addr ),
        .wr_data ( link_wr_data ),
        .rd_en   ( link_rd_en ),
        .rd_addr ( link_rd_addr ),
        .rd_data ( link_rd_data )
    );

    // ----------------------------------------
    // Pool and queue
    // ----------------------------------------
    buf_alloc i_buf_alloc (
        .clk,
        .rst,
        .take,
        .recycle,
        .recycle_ptr,
        .free_ptr,
        .free_avail,
        .init_done
    );

    desc_fifo i_desc_fifo (
        .clk,
        .rst,
        .push,
        .push_desc,
        .pop,
        .head_desc,
        .not_empty
    );

    // ----------------------------------------
    // Writer and reader
    // ----------------------------------------
    pkt_scatter i_pkt_scatter (
        .clk,
        .rst,
        .in_valid,
        .in_word,
        .in_meta,
        .free_ptr,
        .free_avail,
        .take,
        .data_wr_en,
        .data_wr_addr,
        .data_wr_data,
        .link_wr_en,
        .link_wr_addr,
        .link_wr_data,
        .push,
        .push_desc,
        .drop_cnt
    );

    pkt_gather i_pkt_gather (
        .clk,
        .rst,
        .drain_en,
        .head_desc,
        .not_empty,
        .data_rd_data,
        .link_rd_data,
        .pop,
        .data_rd_en,
        .data_rd_addr,
        .link_rd_en,
        .link_rd_addr,
        .recycle,
        .recycle_ptr,
        .out_valid,
        .out_word,
        .out_meta
    );

endmodule : pkt_q_core

/* test/pkt_q_tb.sv */
`timescale 1ns/100ps

module pkt_q_tb
    import pkt_q_pkg::*;
();

    logic                    clk;
    logic                    rst;
    logic                    in_valid;
    pkt_word_t               in_word;
    meta_t                   in_meta;
    logic                    drain_en;
    logic                    out_valid;
    pkt_word_t               out_word;
    meta_t                   out_meta;
    logic                    init_done;
    logic [DROP_CNT_WID-1:0] drop_cnt;
    logic                    out_sop;

    // Reference model
    pkt_word_t   exp_words [$];
    meta_t       exp_metas [$];
    pkt_word_t   exp_word;
    meta_t       exp_meta;
    logic        exp_present;
    logic        out_open;
    logic        pool_ready;
    int          exp_drops;
    int          free_cnt;
    int          trailing;    // Buffers held by drops queued after the last kept packet

    int          err_cnt = 0;
    int          words_sent = 0;
    int          words_out = 0;
    int          pkts_sent = 0;
    int          cycle_cnt = 0;
    int          init_cycles = 0;
    logic [31:0] rng;
    string       test_name;

    assign out_sop = out_word.sop;

    pkt_q_core i_pkt_q_core (
        .clk,
        .rst,
        .in_valid,
        .in_word,
        .in_meta,
        .drain_en,
        .out_valid,
        .out_word,
        .out_meta,
        .init_done,
        .drop_cnt
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic int random_len();
        logic [31:0] r;
        r = next_rand();
        return MIN_PKT_WORDS + int'(r % (MAX_PKT_WORDS - MIN_PKT_WORDS + 1));
    endfunction

    // Buffers a packet ties up, counting only the words that are stored
    function automatic int bufs_for(input int len);
        int kept;
        kept = (len > MAX_PKT_WORDS) ? MAX_PKT_WORDS : len;
        return (kept + BUF_WORDS - 1) / BUF_WORDS;
    endfunction

    function automatic void refresh_head();
        exp_present = (exp_words.size() != 0);
        if (exp_present) begin
            exp_word = exp_words[0];
            exp_meta = exp_metas[0];
        end
    endfunction

    task automatic wait_drained();
        while (exp_words.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
        free_cnt = NUM_BUFS - trailing;
    endtask

    task automatic send_packet(input int len, input logic err);
        logic [31:0] r;
        meta_t       meta;
        pkt_word_t   w;
        int          need;
        int          held;
        int          i;
        logic        keep;
        if (drain_en && pool_ready && bufs_for(len) > free_cnt) begin
            wait_drained();
        end
        need = bufs_for(len);
        held = !pool_ready ? 0 : ((need < free_cnt) ? need : free_cnt);
        keep = pool_ready && (need <= free_cnt) && !err &&
               (len >= MIN_PKT_WORDS) && (len <= MAX_PKT_WORDS);
        free_cnt -= held;
        trailing = keep ? 0 : trailing + held;
        if (!keep) begin
            exp_drops++;
        end
        r = next_rand();
        meta = r[7:0];
        for (i = 0; i < len; i++) begin
            @(negedge clk);
            r = next_rand();
            w = '{data: r, sop: (i == 0), eop: (i == len - 1), err: err && (i == len - 1)};
            in_valid = 1'b1;
            in_word  = w;
            in_meta  = meta;
            words_sent++;
            if (keep) begin
                w.err = 1'b0;
                exp_words.push_back(w);
                exp_metas.push_back(meta);
                refresh_head();
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
        in_word  = '0;
        pkts_sent++;
        // Counter moves one cycle after the end word
        assert (drop_cnt == DROP_CNT_WID'(exp_drops)) else begin
            err_cnt++;
            $display("[FAIL] %s drop_cnt: expected %0d, actual %0d",
                     test_name, exp_drops, drop_cnt);
        end
        r = next_rand();
        repeat (r % 3) @(negedge clk);
    endtask

    // ----------------------------------------
    // Output checking
    // ----------------------------------------
    always @(posedge clk) begin
        if (rst) begin
            out_open = 1'b0;
        end else if (out_valid) begin
            out_open = !out_word.eop;
            words_out++;
            if (exp_words.size() != 0) begin
                void'(exp_words.pop_front());
                void'(exp_metas.pop_front());
            end
            refresh_head();
        end
    end

    assert property (@(posedge clk) disable iff (rst) out_valid |-> exp_present)
        else begin
            err_cnt++;
            $display("Output word arrived in %s while no packet was expected", test_name);
        end

    assert property (@(posedge clk) disable iff (rst)
                     out_valid && exp_present |-> out_word == exp_word)
        else begin
            err_cnt++;
            $display("[FAIL] %s out_word: expected %h, actual %h",
                     test_name, $sampled(exp_word), $sampled(out_word));
        end

    assert property (@(posedge clk) disable iff (rst)
                     out_valid && exp_present && out_sop |-> out_meta == exp_meta)
        else begin
            err_cnt++;
            $display("[FAIL] %s out_meta: expected %h, actual %h",
                     test_name, $sampled(exp_meta), $sampled(out_meta));
        end

    // A packet opens with sop only after the previous one closed with eop
    assert property (@(posedge clk) disable iff (rst) out_valid |-> out_sop == !out_open)
        else begin
            err_cnt++;
            $display("[FAIL] %s sop: expected %b, actual %b",
                     test_name, !$sampled(out_open), $sampled(out_sop));
        end

    assert property (@(posedge clk) disable iff (rst) !$past(drain_en) |-> !out_valid)
        else begin
            err_cnt++;
            $display("Output word appeared in %s one cycle after drain_en was low", test_name);
        end

    always @(posedge clk) begin
        if (rst) begin
            init_cycles = 0;
        end else if (!init_done) begin
            init_cycles++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > 4 * words_sent + 200) begin
            $display("Timeout after %0d cycles, the DUT stopped delivering packets", cycle_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        int len;
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_word     = '0;
        in_meta     = '0;
        drain_en    = 1'b1;
        rng         = 32'he24da7a0;
        exp_drops   = 0;
        free_cnt    = 0;
        trailing    = 0;
        pool_ready  = 1'b0;
        exp_present = 1'b0;
        exp_word    = '0;
        exp_meta    = '0;
        out_open    = 1'b0;
        test_name   = "reset";
        repeat (3) @(negedge clk);
        rst = 1'b0;

        // Pool still filling
        test_name = "before_init";
        send_packet(4, 1'b0);
        while (!init_done) begin
            @(negedge clk);
        end
        assert (init_cycles <= NUM_BUFS + 2) else begin
            err_cnt++;
            $display("[FAIL] %s init cycles: expected at most %0d, actual %0d",
                     test_name, NUM_BUFS + 2, init_cycles);
        end
        pool_ready = 1'b1;
        free_cnt   = NUM_BUFS;

        test_name = "ordering";
        repeat (30) send_packet(random_len(), 1'b0);

        test_name = "errored";
        send_packet(random_len(), 1'b0);
        send_packet(random_len(), 1'b1);
        send_packet(random_len(), 1'b0);

        test_name = "length_limits";
        send_packet(random_len(), 1'b0);
        send_packet(1, 1'b0);
        send_packet(random_len(), 1'b0);
        send_packet(MAX_PKT_WORDS + 4, 1'b0);
        send_packet(random_len(), 1'b0);

        // Reader stalled, so the pool only shrinks
        test_name = "exhaustion";
        wait_drained();
        drain_en = 1'b0;
        len = random_len();
        while (bufs_for(len) <= free_cnt) begin
            send_packet(len, 1'b0);
            len = random_len();
        end
        send_packet(len, 1'b0);
        repeat (2) send_packet(random_len(), 1'b0);

        test_name = "resume";
        drain_en = 1'b1;
        wait_drained();
        repeat (8) send_packet(random_len(), 1'b0);
        wait_drained();

        assert (drop_cnt == DROP_CNT_WID'(exp_drops)) else begin
            err_cnt++;
            $display("[FAIL] closing drop_cnt: expected %0d, actual %0d", exp_drops, drop_cnt);
        end

        $display("Closing report: %0d errors, %0d packets sent, %0d dropped, %0d words out",
                 err_cnt, pkts_sent, exp_drops, words_out);
        if (err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : pkt_q_tb

/* files.f */
rtl/pkt_q_pkg.sv
rtl/buf_ram.sv
rtl/buf_alloc.sv
rtl/desc_fifo.sv
rtl/pkt_scatter.sv
rtl/pkt_gather.sv
rtl/pkt_q_core.sv
test/pkt_q_tb.sv
